//--- rtl/mmu_pkg.sv
/*
 * Sv32 MMU shared types
 * Address and PTE widths, access and privilege encodings, handshake payloads
 */
package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [31:0] pte_t;
    typedef logic [3:0]  cause_t;

    localparam int TLB_ENTRIES   = 4;
    localparam int TLB_IDX_W     = $clog2(TLB_ENTRIES);
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_PART_W    = 10;

    localparam cause_t CAUSE_FETCH_PAGE_FAULT = 4'd12;
    localparam cause_t CAUSE_LOAD_PAGE_FAULT  = 4'd13;
    localparam cause_t CAUSE_STORE_PAGE_FAULT = 4'd15;

    // Value picks the TLB and the permission bit
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } access_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        L1_REQ,
        L1_WAIT,
        L0_REQ,
        L0_WAIT,
        DONE
    } walk_state_e;

    typedef struct packed {
        vaddr_t  vaddr;
        access_e access;
        priv_e   priv;
        logic    satp_mode;
        ppn_t    satp_ppn;
        logic    sum;
        logic    mxr;
    } xlat_req_t;

    typedef struct packed {
        paddr_t paddr;
        logic   fault;
        cause_t cause;
    } xlat_rsp_t;

    typedef struct packed {
        xlat_req_t req;
        logic      translate;
    } walk_job_t;

endpackage

//--- rtl/xlat_req_stage.sv
/*
 * Translation request register
 * Holds one request and flags whether it needs translation or bypasses
 */
`timescale 1ns/10ps

module xlat_req_stage
    import mmu_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  logic      req_valid,
    input  xlat_req_t req,
    input  logic      job_ready,
    output logic      req_ready,
    output logic      job_valid,
    output walk_job_t job
);

    // Empty, or emptying in this cycle
    assign req_ready = !job_valid || job_ready;

    always_ff @(posedge CLK) begin
        if (reset) begin
            job_valid <= 1'b0;
        end else if (req_ready) begin
            job_valid <= req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid && req_ready) begin
            job.req       <= req;
            // M-mode and satp mode off go straight through
            job.translate <= req.satp_mode && (req.priv != PRIV_M);
        end
    end

endmodule

//--- rtl/sv32_tlb.sv
/*
 * Direct-mapped Sv32 TLB, one bank per access kind
 * Combinational lookup, single-entry fill, flush of all valid bits
 */
`timescale 1ns/10ps

module sv32_tlb
    import mmu_pkg::*;
#(
    parameter int ENTRIES = TLB_ENTRIES
) (
    input  logic    CLK,
    input  logic    reset,
    input  logic    flush,
    input  access_e lookup_kind,
    input  vpn_t    lookup_vpn,
    input  logic    fill,
    input  access_e fill_kind,
    input  vpn_t    fill_vpn,
    input  ppn_t    fill_ppn,
    output logic    hit,
    output ppn_t    hit_ppn
);

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_W = $bits(vpn_t) - IDX_W;

    logic [TAG_W-1:0]   tag_q   [3][ENTRIES];
    ppn_t               ppn_q   [3][ENTRIES];
    logic [ENTRIES-1:0] valid_q [3];

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [TAG_W-1:0] fill_tag;
    logic             lookup_kind_ok;
    logic             fill_kind_ok;

    assign {lookup_tag, lookup_idx} = lookup_vpn;
    assign {fill_tag, fill_idx}     = fill_vpn;

    // Encoding 3 has no bank
    assign lookup_kind_ok = (lookup_kind != 2'd3);
    assign fill_kind_ok   = (fill_kind != 2'd3);

    assign hit     = lookup_kind_ok && valid_q[lookup_kind][lookup_idx]
                     && (tag_q[lookup_kind][lookup_idx] == lookup_tag);
    assign hit_ppn = ppn_q[lookup_kind][lookup_idx];

    always_ff @(posedge CLK) begin
        if (fill && fill_kind_ok) begin
            tag_q[fill_kind][fill_idx] <= fill_tag;
            ppn_q[fill_kind][fill_idx] <= fill_ppn;
        end
    end

    // Flush beats a fill in the same cycle
    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            valid_q <= '{default: '0};
        end else if (fill && fill_kind_ok) begin
            valid_q[fill_kind][fill_idx] <= 1'b1;
        end
    end

endmodule

//--- rtl/pte_check.sv
/*
 * Sv32 PTE check for one walk level
 * Flags leaf entries and faults from V, R/W encoding and U/SUM/MXR rules
 */
`timescale 1ns/10ps

module pte_check
    import mmu_pkg::*;
(
    input  pte_t    pte,
    input  access_e access,
    input  priv_e   priv,
    input  logic    sum,
    input  logic    mxr,
    output logic    leaf,
    output logic    fault
);

    logic       v;
    logic       r;
    logic       w;
    logic       x;
    logic       u;
    logic       r_eff;
    logic       priv_fault;
    logic [3:0] perm;

    assign v = pte[0];
    assign r = pte[1];
    assign w = pte[2];
    assign x = pte[3];
    assign u = pte[4];

    // Executable pages readable under MXR
    assign r_eff = r || (mxr && x);

    // Indexed by access kind, top slot is the unused encoding
    assign perm = {1'b0, w, r_eff, x};

    assign leaf = r || w || x;

    assign priv_fault = ((priv == PRIV_S) && u && !sum)
                        || ((priv == PRIV_U) && !u);

    // W without R is reserved at any level
    assign fault = !v || (w && !r) || (leaf && (priv_fault || !perm[access]));

endmodule

//--- rtl/page_walker.sv
/*
 * Sv32 page walker
 * TLB lookup, two-level PTE walk with superpages, TLB fill and result forming
 */
`timescale 1ns/10ps

module page_walker
    import mmu_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  logic      job_valid,
    input  walk_job_t job,
    input  logic      res_ready,
    input  logic      tlb_hit,
    input  ppn_t      tlb_ppn,
    input  logic      mem_req_ready,
    input  logic      mem_rsp_valid,
    input  pte_t      mem_rsp_data,
    output logic      job_ready,
    output logic      res_valid,
    output xlat_rsp_t res,
    output access_e   tlb_kind,
    output vpn_t      tlb_vpn,
    output logic      tlb_fill,
    output ppn_t      tlb_fill_ppn,
    output logic      mem_req_valid,
    output paddr_t    mem_addr
);

    walk_state_e state;
    walk_job_t   job_q;
    xlat_rsp_t   res_q;
    ppn_t        l0_base_q;

    logic [VPN_PART_W-1:0]    vpn1;
    logic [VPN_PART_W-1:0]    vpn0;
    logic [PAGE_OFFSET_W-1:0] offset;
    logic                     pte_leaf;
    logic                     pte_fault;
    logic                     in_wait;
    logic                     walk_end;
    cause_t                   fault_cause;

    assign vpn1   = job_q.req.vaddr[31:22];
    assign vpn0   = job_q.req.vaddr[21:12];
    assign offset = job_q.req.vaddr[PAGE_OFFSET_W-1:0];

    pte_check u_pte_check (
        .pte    (mem_rsp_data),
        .access (job_q.req.access),
        .priv   (job_q.req.priv),
        .sum    (job_q.req.sum),
        .mxr    (job_q.req.mxr),
        .leaf   (pte_leaf),
        .fault  (pte_fault)
    );

    always_comb begin
        case (job_q.req.access)
            FETCH:   fault_cause = CAUSE_FETCH_PAGE_FAULT;
            LOAD:    fault_cause = CAUSE_LOAD_PAGE_FAULT;
            default: fault_cause = CAUSE_STORE_PAGE_FAULT;
        endcase
    end

    // Walk ends on a fault or leaf at L1, or on any L0 response
    assign in_wait  = (state == L1_WAIT) || (state == L0_WAIT);
    assign walk_end = mem_rsp_valid && ((state == L0_WAIT)
                      || ((state == L1_WAIT) && (pte_fault || pte_leaf)));

    assign tlb_kind = job_q.req.access;
    assign tlb_vpn  = job_q.req.vaddr[31:PAGE_OFFSET_W];
    assign tlb_fill = mem_rsp_valid && in_wait && pte_leaf && !pte_fault;

    // Superpage entries cached as 4 KiB pages with vpn0 folded in
    assign tlb_fill_ppn = (state == L1_WAIT) ? {mem_rsp_data[29:20], vpn0}
                                             : mem_rsp_data[29:10];

    assign mem_req_valid = (state == L1_REQ) || (state == L0_REQ);
    assign mem_addr      = (state == L0_REQ) ? {l0_base_q, vpn0, 2'b00}
                                             : {job_q.req.satp_ppn, vpn1, 2'b00};

    assign job_ready = (state == IDLE);
    assign res_valid = (state == DONE);
    assign res       = res_q;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (job_valid) state <= LOOKUP;
                LOOKUP:  state <= (!job_q.translate || tlb_hit) ? DONE : L1_REQ;
                L1_REQ:  if (mem_req_ready) state <= L1_WAIT;
                L1_WAIT: if (mem_rsp_valid) state <= (pte_fault || pte_leaf) ? DONE : L0_REQ;
                L0_REQ:  if (mem_req_ready) state <= L0_WAIT;
                L0_WAIT: if (mem_rsp_valid) state <= DONE;
                DONE:    if (res_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (job_valid && job_ready) begin
            job_q <= job;
        end
        if ((state == L1_WAIT) && mem_rsp_valid) begin
            l0_base_q <= mem_rsp_data[29:10];
        end
        if (state == LOOKUP) begin
            res_q.paddr <= job_q.translate ? {tlb_ppn, offset} : job_q.req.vaddr;
            res_q.fault <= 1'b0;
            res_q.cause <= '0;
        end else if (walk_end) begin
            res_q.paddr <= tlb_fill ? {tlb_fill_ppn, offset} : '0;
            res_q.fault <= !tlb_fill;
            res_q.cause <= tlb_fill ? cause_t'(0) : fault_cause;
        end
    end

endmodule

//--- rtl/xlat_rsp_stage.sv
/*
 * Translation response register
 * One-entry output buffer, holds its result under back-pressure
 */
`timescale 1ns/10ps

module xlat_rsp_stage
    import mmu_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  logic      res_valid,
    input  xlat_rsp_t res,
    input  logic      rsp_ready,
    output logic      res_ready,
    output logic      rsp_valid,
    output xlat_rsp_t rsp
);

    // Refill allowed in the cycle the held result leaves
    assign res_ready = !rsp_valid || rsp_ready;

    always_ff @(posedge CLK) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (res_ready) begin
            rsp_valid <= res_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (res_valid && res_ready) begin
            rsp <= res;
        end
    end

endmodule

//--- rtl/sv32_mmu.sv
/*
 * Sv32 address translation unit top
 * Request register, page walker with per-kind TLBs, response register
 */
`timescale 1ns/10ps

module sv32_mmu
    import mmu_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  logic      req_valid,
    output logic      req_ready,
    input  xlat_req_t req,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output xlat_rsp_t rsp,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output paddr_t    mem_addr,
    input  logic      mem_rsp_valid,
    input  pte_t      mem_rsp_data,
    input  logic      tlb_flush
);

    logic      job_valid;
    logic      job_ready;
    walk_job_t job;
    logic      res_valid;
    logic      res_ready;
    xlat_rsp_t res;
    access_e   tlb_kind;
    vpn_t      tlb_vpn;
    logic      tlb_fill;
    ppn_t      tlb_fill_ppn;
    logic      tlb_hit;
    ppn_t      tlb_ppn;

    xlat_req_stage u_req_stage (
        .CLK       (CLK),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .job_ready (job_ready),
        .req_ready (req_ready),
        .job_valid (job_valid),
        .job       (job)
    );

    page_walker u_walker (
        .CLK           (CLK),
        .reset         (reset),
        .job_valid     (job_valid),
        .job           (job),
        .res_ready     (res_ready),
        .tlb_hit       (tlb_hit),
        .tlb_ppn       (tlb_ppn),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .job_ready     (job_ready),
        .res_valid     (res_valid),
        .res           (res),
        .tlb_kind      (tlb_kind),
        .tlb_vpn       (tlb_vpn),
        .tlb_fill      (tlb_fill),
        .tlb_fill_ppn  (tlb_fill_ppn),
        .mem_req_valid (mem_req_valid),
        .mem_addr      (mem_addr)
    );

    // Fill goes to the entry that was just looked up
    sv32_tlb #(
        .ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .CLK         (CLK),
        .reset       (reset),
        .flush       (tlb_flush),
        .lookup_kind (tlb_kind),
        .lookup_vpn  (tlb_vpn),
        .fill        (tlb_fill),
        .fill_kind   (tlb_kind),
        .fill_vpn    (tlb_vpn),
        .fill_ppn    (tlb_fill_ppn),
        .hit         (tlb_hit),
        .hit_ppn     (tlb_ppn)
    );

    xlat_rsp_stage u_rsp_stage (
        .CLK       (CLK),
        .reset     (reset),
        .res_valid (res_valid),
        .res       (res),
        .rsp_ready (rsp_ready),
        .res_ready (res_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

//--- dv/mmu_tb.sv
/*
 * Sv32 MMU testbench
 * Page-table memory model, vector table with expected results and read counts
 */
`timescale 1ns/10ps

module mmu_tb
    import mmu_pkg::*;
;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          MEM_WORDS      = 4096;
    localparam int          MAX_ROWS       = 32;
    localparam logic [31:0] LFSR_SEED      = 32'h3b62b763;
    localparam ppn_t        ROOT_PPN       = 20'h00001;

    typedef struct packed {
        xlat_req_t  req;
        logic       flush;
        xlat_rsp_t  exp;
        logic [3:0] reads;
    } row_t;

    logic      CLK;
    logic      reset;
    logic      req_valid;
    logic      req_ready;
    xlat_req_t req;
    logic      rsp_valid;
    logic      rsp_ready;
    xlat_rsp_t rsp;
    logic      mem_req_valid;
    logic      mem_req_ready;
    paddr_t    mem_addr;
    logic      mem_rsp_valid;
    pte_t      mem_rsp_data;
    logic      tlb_flush;

    pte_t        mem [MEM_WORDS];
    row_t        rows [MAX_ROWS];
    int          n_rows;
    int          cur_row;
    int          mem_reads;
    int          rsp_errors;
    int          read_errors;
    int          addr_errors;
    int          timeouts;
    logic        aborted;
    logic [31:0] bp_lfsr;

    sv32_mmu u_dut (
        .CLK           (CLK),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_addr      (mem_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .tlb_flush     (tlb_flush)
    );

    always #50 CLK = ~CLK;

    // Fibonacci LFSR, taps 32/22/2/1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic pte_t make_pte(input ppn_t ppn, input logic [9:0] flags);
        return {2'b00, ppn, flags};
    endfunction

    // Expected PTE address for read n of a walk
    function automatic paddr_t walk_addr(input vaddr_t va, input int n);
        paddr_t l1_addr;
        pte_t   l1_pte;
        l1_addr = paddr_t'(ROOT_PPN) * 4096 + paddr_t'(va[31:22]) * 4;
        l1_pte  = mem[l1_addr[13:2]];
        if (n == 0) begin
            return l1_addr;
        end
        return paddr_t'(l1_pte[29:10]) * 4096 + paddr_t'(va[21:12]) * 4;
    endfunction

    task automatic load_memory();
        // Unlisted words are invalid PTEs tagged with their word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = pte_t'({i[21:0], 10'h000});
        end
        // Root table at 0x1000
        mem[12'h400] = make_pte(20'h00002, 10'h001);
        mem[12'h401] = make_pte(20'h40000, 10'h007);
        mem[12'h402] = make_pte(20'h12345, 10'h00e);
        mem[12'h403] = make_pte(20'h00003, 10'h005);
        // Second level table at 0x2000
        mem[12'h801] = make_pte(20'h12345, 10'h007);
        mem[12'h802] = make_pte(20'h22222, 10'h003);
        mem[12'h803] = make_pte(20'h33333, 10'h017);
        mem[12'h804] = make_pte(20'h44444, 10'h009);
        mem[12'h805] = make_pte(20'h55555, 10'h00b);
        mem[12'h807] = make_pte(20'h00002, 10'h001);
    endtask

    // A cause of zero means no fault expected
    task automatic add_row(input vaddr_t va, input access_e acc, input priv_e pv,
                           input logic mode, input logic s, input logic m, input logic fl,
                           input paddr_t pa, input cause_t cause, input int reads);
        row_t r;
        r.req.vaddr     = va;
        r.req.access    = acc;
        r.req.priv      = pv;
        r.req.satp_mode = mode;
        r.req.satp_ppn  = ROOT_PPN;
        r.req.sum       = s;
        r.req.mxr       = m;
        r.flush         = fl;
        r.exp.paddr     = pa;
        r.exp.fault     = (cause != 0);
        r.exp.cause     = cause;
        r.reads         = reads[3:0];
        rows[n_rows]    = r;
        n_rows++;
    endtask

    task automatic load_table();
        //      vaddr         kind   priv    md su mx fl paddr        cause reads
        add_row(32'h8765_4321, LOAD,  PRIV_M, 1, 0, 0, 0, 32'h8765_4321, 0,  0);
        add_row(32'h0000_1abc, STORE, PRIV_S, 0, 0, 0, 0, 32'h0000_1abc, 0,  0);
        add_row(32'h0000_1abc, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h1234_5abc, 0,  2);
        add_row(32'h0000_1123, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h1234_5123, 0,  0);
        add_row(32'h0056_7abc, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h4016_7abc, 0,  1);
        add_row(32'h0056_7000, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h4016_7000, 0,  0);
        add_row(32'h0080_0010, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 13, 1);
        add_row(32'h0080_0010, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 13, 1);
        add_row(32'h00c0_0020, FETCH, PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 12, 1);
        add_row(32'h0000_2040, STORE, PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 15, 2);
        add_row(32'h0000_2040, STORE, PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 15, 2);
        add_row(32'h0000_2040, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h2222_2040, 0,  2);
        add_row(32'h0000_3100, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 13, 2);
        add_row(32'h0000_3100, LOAD,  PRIV_S, 1, 1, 0, 0, 32'h3333_3100, 0,  2);
        add_row(32'h0000_3100, STORE, PRIV_U, 1, 0, 0, 0, 32'h3333_3100, 0,  2);
        add_row(32'h0000_1800, STORE, PRIV_U, 1, 0, 0, 0, 32'h0000_0000, 15, 2);
        add_row(32'h0000_4200, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 13, 2);
        add_row(32'h0000_4200, LOAD,  PRIV_S, 1, 0, 1, 0, 32'h4444_4200, 0,  2);
        add_row(32'h0000_5300, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h5555_5300, 0,  2);
        add_row(32'h0000_5300, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h5555_5300, 0,  0);
        add_row(32'h0000_5300, FETCH, PRIV_S, 1, 0, 0, 0, 32'h5555_5300, 0,  2);
        add_row(32'h0000_5310, FETCH, PRIV_S, 1, 0, 0, 0, 32'h5555_5310, 0,  0);
        add_row(32'h0000_5300, LOAD,  PRIV_S, 1, 0, 0, 1, 32'h5555_5300, 0,  2);
        add_row(32'h0000_5300, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h5555_5300, 0,  0);
        add_row(32'h0000_6000, FETCH, PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 12, 2);
        add_row(32'h0000_7000, LOAD,  PRIV_S, 1, 0, 0, 0, 32'h0000_0000, 13, 2);
    endtask

    // Paddr only matters when no fault is expected
    task automatic check_rsp(input xlat_rsp_t got, input xlat_rsp_t exp, input int idx);
        logic bad;
        bad = (got.fault !== exp.fault) || (got.cause !== exp.cause)
              || (!exp.fault && (got.paddr !== exp.paddr));
        if (bad) begin
            rsp_errors++;
            $display("FAILED %0t: row %0d paddr %h fault %b cause %0d, expected %h %b %0d",
                     $time, idx, got.paddr, got.fault, got.cause,
                     exp.paddr, exp.fault, exp.cause);
        end
    endtask

    task automatic check_reads(input int got, input int exp, input int idx);
        if (got != exp) begin
            read_errors++;
            $display("FAILED %0t: row %0d took %0d memory reads, expected %0d",
                     $time, idx, got, exp);
        end
    endtask

    task automatic check_addr(input paddr_t got, input paddr_t exp, input int idx);
        if (got !== exp) begin
            addr_errors++;
            $display("FAILED %0t: row %0d read PTE at %h, expected %h",
                     $time, idx, got, exp);
        end
    endtask

    task automatic apply_row(input int idx);
        row_t      row;
        xlat_rsp_t got;
        int        waited;
        logic      done;
        row = rows[idx];
        if (row.flush) begin
            tlb_flush = 1'b1;
            @(negedge CLK);
            tlb_flush = 1'b0;
        end
        cur_row   = idx;
        mem_reads = 0;
        req       = row.req;
        req_valid = 1'b1;
        waited    = 0;
        while (!req_ready && waited < TIMEOUT_CYCLES) begin
            @(negedge CLK);
            waited++;
        end
        if (!req_ready) begin
            $display("Timeout: request of row %0d was never accepted", idx);
            timeouts++;
            aborted = 1'b1;
            return;
        end
        @(negedge CLK);
        req_valid = 1'b0;
        waited    = 0;
        done      = 1'b0;
        while (!done && waited < TIMEOUT_CYCLES) begin
            // Ready low on about a quarter of the cycles
            bp_lfsr   = lfsr_step(bp_lfsr);
            rsp_ready = bp_lfsr[0];
            bp_lfsr   = lfsr_step(bp_lfsr);
            rsp_ready = rsp_ready | bp_lfsr[0];
            if (rsp_valid && rsp_ready) begin
                done = 1'b1;
                got  = rsp;
            end
            @(negedge CLK);
            waited++;
        end
        rsp_ready = 1'b0;
        if (!done) begin
            $display("Timeout: no response arrived for row %0d", idx);
            timeouts++;
            aborted = 1'b1;
            return;
        end
        check_rsp(got, row.exp, idx);
        check_reads(mem_reads, row.reads, idx);
    endtask

    // Answers one PTE read at a time after 0 to 3 extra cycles
    initial begin : mem_model
        logic [31:0] lfsr_state;
        paddr_t      addr;
        int          delay;
        lfsr_state    = LFSR_SEED;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever begin
            @(negedge CLK);
            mem_rsp_valid = 1'b0;
            if (!reset && mem_req_valid && mem_req_ready) begin
                addr = mem_addr;
                check_addr(addr, walk_addr(rows[cur_row].req.vaddr, mem_reads), cur_row);
                mem_reads++;
                delay = 0;
                repeat (2) begin
                    lfsr_state = lfsr_step(lfsr_state);
                    delay      = delay * 2 + lfsr_state[0];
                end
                repeat (delay + 1) @(negedge CLK);
                mem_rsp_data  = mem[addr[13:2]];
                mem_rsp_valid = 1'b1;
            end
        end
    end

    initial begin
        CLK           = 1'b0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        rsp_ready     = 1'b0;
        mem_req_ready = 1'b0;
        tlb_flush     = 1'b0;
        n_rows        = 0;
        cur_row       = 0;
        mem_reads     = 0;
        rsp_errors    = 0;
        read_errors   = 0;
        addr_errors   = 0;
        timeouts      = 0;
        aborted       = 1'b0;
        bp_lfsr       = LFSR_SEED;
        load_memory();
        load_table();
        repeat (8) @(negedge CLK);
        reset         = 1'b0;
        mem_req_ready = 1'b1;
        for (int i = 0; i < n_rows && !aborted; i++) begin
            apply_row(i);
        end
        $display("Errors: response %0d, read count %0d, address %0d, timeout %0d",
                 rsp_errors, read_errors, addr_errors, timeouts);
        if (rsp_errors + read_errors + addr_errors + timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/mmu_pkg.sv
rtl/xlat_req_stage.sv
rtl/sv32_tlb.sv
rtl/pte_check.sv
rtl/page_walker.sv
rtl/xlat_rsp_stage.sv
rtl/sv32_mmu.sv
dv/mmu_tb.sv

//--- Bender.yml
package:
  name: sv32_mmu

sources:
  - files:
      - rtl/mmu_pkg.sv
      - rtl/xlat_req_stage.sv
      - rtl/sv32_tlb.sv
      - rtl/pte_check.sv
      - rtl/page_walker.sv
      - rtl/xlat_rsp_stage.sv
      - rtl/sv32_mmu.sv
  - target: simulation
    files:
      - dv/mmu_tb.sv
